/* board_demo.f */
hw/board_pkg.sv
hw/slow_clk_gen.sv
hw/mic_i2s_receiver.sv
hw/seven_segment_scan.sv
hw/vga_sync.sv
hw/lab_top.sv
hw/board_top.sv
tb/board_top_asserts.sv
tb/board_top_tb.sv

/* hw/board_pkg.sv */
package board_pkg;

    // --------------------------------------------------
    // fixed widths

    localparam int w_color = 4;   // bits per colour channel
    localparam int w_mic   = 24;  // INMP441 sample
    localparam int w_coord = 10;  // screen coordinate

    // --------------------------------------------------
    // video

    typedef struct packed
    {
        logic [w_color - 1:0] red;
        logic [w_color - 1:0] green;
        logic [w_color - 1:0] blue;
    } rgb_t;

    typedef struct packed
    {
        logic hsync;       // active low
        logic vsync;       // active low
        logic display_on;  // inside visible area
    } vga_sync_t;

    typedef struct packed
    {
        logic [w_coord - 1:0] x;
        logic [w_coord - 1:0] y;
    } pixel_pos_t;

    // --------------------------------------------------
    // display modes, picked by sw[1:0]

    typedef enum logic [1:0]
    {
        mode_mic   = 2'd0,
        mode_keys  = 2'd1,
        mode_count = 2'd2
    } disp_mode_t;

endpackage

/* hw/board_top.sv */
`timescale 1ns/1ns

module board_top
#(
    parameter clk_mhz     = 27,
              slow_clk_hz = 1,
              sck_div     = 8,
              w_key       = 4,
              w_sw        = 5,
              w_led       = 6,
              w_digit     = 4,
              h_visible   = 640, h_front = 16, h_sync = 96, h_back = 48,
              v_visible   = 480, v_front = 10, v_sync = 2,  v_back = 33
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [w_key - 1:0]   key,       // active low
    input  logic [w_sw  - 1:0]   sw,        // active low
    output logic [w_led - 1:0]   led,       // active low
    output logic [7:0]           abcdefgh,  // h first
    output logic [w_digit - 1:0] digit,
    output logic                 mic_sck,
    output logic                 mic_ws,
    output logic                 mic_lr,
    input  logic                 mic_sd,
    output logic [7:0]           gpio_2,
    output logic [5:0]           gpio_3
);

    logic [w_key - 1:0]            lab_key;
    logic [w_sw  - 1:0]            lab_sw;
    logic [w_led - 1:0]            lab_led;
    logic [7:0]                    lab_abcdefgh;
    logic                          slow_clk;
    logic [board_pkg::w_mic - 1:0] mic_value;
    board_pkg::rgb_t               rgb;
    board_pkg::vga_sync_t          sync;

    // --------------------------------------------------
    // board polarity and segment order

    assign lab_key = ~key;
    assign lab_sw  = ~sw;
    assign led     = ~lab_led;

    for (genvar i = 0; i < 8; i++)
    begin : g_seg_rev
        assign abcdefgh[i] = lab_abcdefgh[7 - i];
    end

    // 4-4-4 vga map
    assign gpio_2 = {rgb.blue, rgb.red};
    assign gpio_3 = {sync.vsync, sync.hsync, rgb.green};

    // --------------------------------------------------

    slow_clk_gen #(.fast_clk_mhz(clk_mhz), .slow_clk_hz(slow_clk_hz)) i_slow_clk_gen
        (.clk(clk), .rst(rst), .slow_clk(slow_clk));

    mic_i2s_receiver #(.sck_div(sck_div)) i_microphone
    (
        .clk   ( clk       ),
        .rst   ( rst       ),
        .sck   ( mic_sck   ),
        .ws    ( mic_ws    ),
        .lr    ( mic_lr    ),
        .sd    ( mic_sd    ),
        .value ( mic_value )
    );

    lab_top
    #(
        .w_key     ( w_key     ), .w_sw    ( w_sw    ), .w_led  ( w_led  ), .w_digit ( w_digit ),
        .h_visible ( h_visible ), .h_front ( h_front ), .h_sync ( h_sync ), .h_back  ( h_back  ),
        .v_visible ( v_visible ), .v_front ( v_front ), .v_sync ( v_sync ), .v_back  ( v_back  )
    )
    i_lab_top
    (
        .clk       ( clk          ),
        .rst       ( rst          ),
        .slow_clk  ( slow_clk     ),
        .key       ( lab_key      ),
        .sw        ( lab_sw       ),
        .mic_value ( mic_value    ),
        .led       ( lab_led      ),
        .abcdefgh  ( lab_abcdefgh ),
        .digit     ( digit        ),
        .rgb       ( rgb          ),
        .sync      ( sync         )
    );

endmodule

/* hw/lab_top.sv */
`timescale 1ns/1ns

module lab_top
#(
    parameter w_key = 4, w_sw = 5, w_led = 6, w_digit = 4,
              h_visible = 640, h_front = 16, h_sync = 96, h_back = 48,
              v_visible = 480, v_front = 10, v_sync = 2,  v_back = 33
)
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          slow_clk,
    input  logic [w_key - 1:0]            key,
    input  logic [w_sw  - 1:0]            sw,
    input  logic [board_pkg::w_mic - 1:0] mic_value,
    output logic [w_led - 1:0]            led,
    output logic [7:0]                    abcdefgh,
    output logic [w_digit - 1:0]          digit,
    output board_pkg::rgb_t               rgb,
    output board_pkg::vga_sync_t          sync
);

    localparam int w_c = board_pkg::w_color;

    board_pkg::disp_mode_t         mode;
    board_pkg::vga_sync_t          raw_sync;
    board_pkg::pixel_pos_t         pos;
    logic                          slow_d1, slow_d2;
    logic [15:0]                   count, disp_word;
    logic [board_pkg::w_mic - 1:0] mag;
    logic [w_led - 1:0]            bar;

    always_comb
    begin
        case (sw[1:0])
            2'd1:    mode = board_pkg::mode_keys;
            2'd2:    mode = board_pkg::mode_count;
            default: mode = board_pkg::mode_mic;
        endcase
        case (mode)
            board_pkg::mode_keys:  disp_word = {8'(sw), 8'(key)};
            board_pkg::mode_count: disp_word = count;
            default:               disp_word = mic_value[board_pkg::w_mic - 1 -: 16];
        endcase
    end

    // level bar, led j lit when the magnitude reaches its bit position
    always_comb
    begin
        mag = mic_value[board_pkg::w_mic - 1] ? ~mic_value + 1'b1 : mic_value;
        for (int j = 0; j < w_led; j++)
            bar[j] = |(mag >> (board_pkg::w_mic - w_led + j));
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            slow_d1 <= 1'b0;
            slow_d2 <= 1'b0;
            count   <= '0;
            led     <= '0;
            sync    <= '{hsync: 1'b1, vsync: 1'b1, display_on: 1'b0};
            rgb     <= '0;
        end
        else
        begin
            slow_d1 <= slow_clk;  // into clk domain
            slow_d2 <= slow_d1;
            if (slow_d1 && !slow_d2)
                count <= count + 1'b1;
            led       <= (mode == board_pkg::mode_mic) ? bar : w_led'(key);
            sync      <= raw_sync;  // colour and sync leave together
            rgb.red   <= raw_sync.display_on ? pos.x[w_c - 1:0] : '0;
            rgb.green <= raw_sync.display_on ? pos.y[w_c - 1:0] : '0;
            rgb.blue  <= (raw_sync.display_on && |key) ? '1 : '0;
        end
    end

    seven_segment_scan #(.w_digit(w_digit)) i_seven_segment_scan
    (
        .clk      ( clk       ),
        .rst      ( rst       ),
        .value    ( disp_word ),
        .abcdefgh ( abcdefgh  ),
        .digit    ( digit     )
    );

    vga_sync
    #(
        .h_visible ( h_visible ), .h_front ( h_front ), .h_sync ( h_sync ), .h_back ( h_back ),
        .v_visible ( v_visible ), .v_front ( v_front ), .v_sync ( v_sync ), .v_back ( v_back )
    )
    i_vga_sync (.clk(clk), .rst(rst), .sync(raw_sync), .pos(pos));

endmodule

/* hw/mic_i2s_receiver.sv */
`timescale 1ns/1ns

module mic_i2s_receiver
#(
    parameter sck_div = 8
)
(
    input  logic                            clk,
    input  logic                            rst,
    output logic                            sck,
    output logic                            ws,
    output logic                            lr,
    input  logic                            sd,
    output logic [board_pkg::w_mic - 1:0]   value
);

    localparam int w_div = sck_div > 1 ? $clog2(sck_div) : 1;

    logic [w_div - 1:0]            div_cnt;
    logic                          sck_toggle;
    logic                          sck_rise;
    logic                          sck_fall;
    logic [5:0]                    bit_cnt;   // sck period within the frame
    logic [board_pkg::w_mic - 1:0] shift;

    // --------------------------------------------------
    // bit clock

    assign sck_toggle = (div_cnt == w_div'(sck_div - 1));
    assign sck_rise   = sck_toggle & ~sck;
    assign sck_fall   = sck_toggle &  sck;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end
        else if (sck_toggle)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // --------------------------------------------------
    // frame of 64 sck periods, ws high in the right slot

    always_ff @(posedge clk)
    begin
        if (rst)
            bit_cnt <= '0;
        else if (sck_fall)
            bit_cnt <= bit_cnt + 1'b1;  // wraps at 64
    end

    assign ws = bit_cnt[5];
    assign lr = 1'b0;  // mic answers in the left slot

    // data starts one sck after ws falls, MSB first
    always_ff @(posedge clk)
    begin
        if (sck_rise && bit_cnt >= 6'd1 && bit_cnt <= 6'd24)
            shift <= {shift[board_pkg::w_mic - 2:0], sd};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            value <= '0;
        else if (sck_fall && bit_cnt == 6'd31)
            value <= shift;  // ws about to rise
    end

endmodule

/* hw/seven_segment_scan.sv */
`timescale 1ns/1ns

module seven_segment_scan
#(
    parameter w_digit = 4
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [15:0]          value,
    output logic [7:0]           abcdefgh,
    output logic [w_digit - 1:0] digit
);

    localparam int w_idx = w_digit > 1 ? $clog2(w_digit) : 1;

    logic [3:0]         scan_cnt;
    logic [w_idx - 1:0] idx;       // digit being driven
    logic [3:0]         nibble;

    function automatic logic [7:0] hex_to_seg(input logic [3:0] hex);
        case (hex)
            4'h0: hex_to_seg = 8'b1111_1100;
            4'h1: hex_to_seg = 8'b0110_0000;
            4'h2: hex_to_seg = 8'b1101_1010;
            4'h3: hex_to_seg = 8'b1111_0010;
            4'h4: hex_to_seg = 8'b0110_0110;
            4'h5: hex_to_seg = 8'b1011_0110;
            4'h6: hex_to_seg = 8'b1011_1110;
            4'h7: hex_to_seg = 8'b1110_0000;
            4'h8: hex_to_seg = 8'b1111_1110;
            4'h9: hex_to_seg = 8'b1111_0110;
            4'ha: hex_to_seg = 8'b1110_1110;
            4'hb: hex_to_seg = 8'b0011_1110;
            4'hc: hex_to_seg = 8'b1001_1100;
            4'hd: hex_to_seg = 8'b0111_1010;
            4'he: hex_to_seg = 8'b1001_1110;
            default: hex_to_seg = 8'b1000_1110;  // f, dot off everywhere
        endcase
    endfunction

    assign nibble = 4'(value >> (4 * idx));  // digits past the word go blank-zero

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            scan_cnt <= '0;
            idx      <= '0;
            digit    <= '0;
            abcdefgh <= '0;
        end
        else
        begin
            scan_cnt <= scan_cnt + 1'b1;
            if (scan_cnt == 4'hf)
                idx <= (idx == w_idx'(w_digit - 1)) ? '0 : idx + 1'b1;
            digit    <= w_digit'(1) << idx;  // one-hot
            abcdefgh <= hex_to_seg(nibble);
        end
    end

endmodule

/* hw/slow_clk_gen.sv */
`timescale 1ns/1ns

module slow_clk_gen
#(
    parameter fast_clk_mhz = 27,
              slow_clk_hz  = 1
)
(
    input  logic clk,
    input  logic rst,
    output logic slow_clk
);

    localparam int half_period = fast_clk_mhz * 1000000 / (2 * slow_clk_hz);
    localparam int w_cnt       = $clog2(half_period + 1);

    logic [w_cnt - 1:0] cnt;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cnt      <= w_cnt'(half_period - 1);
            slow_clk <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt      <= w_cnt'(half_period - 1);  // reload
            slow_clk <= ~slow_clk;
        end
        else
        begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

/* hw/vga_sync.sv */
`timescale 1ns/1ns

module vga_sync
#(
    parameter h_visible = 640,
              h_front   = 16,
              h_sync    = 96,
              h_back    = 48,
              v_visible = 480,
              v_front   = 10,
              v_sync    = 2,
              v_back    = 33
)
(
    input  logic                  clk,
    input  logic                  rst,
    output board_pkg::vga_sync_t  sync,
    output board_pkg::pixel_pos_t pos
);

    localparam int w = board_pkg::w_coord;

    localparam [w - 1:0] h_last       = w'(h_visible + h_front + h_sync + h_back - 1);
    localparam [w - 1:0] v_last       = w'(v_visible + v_front + v_sync + v_back - 1);
    localparam [w - 1:0] h_sync_start = w'(h_visible + h_front);
    localparam [w - 1:0] h_sync_end   = w'(h_visible + h_front + h_sync);
    localparam [w - 1:0] v_sync_start = w'(v_visible + v_front);
    localparam [w - 1:0] v_sync_end   = w'(v_visible + v_front + v_sync);
    localparam [w - 1:0] h_vis        = w'(h_visible);
    localparam [w - 1:0] v_vis        = w'(v_visible);

    logic [w - 1:0] h_cnt;
    logic [w - 1:0] v_cnt;

    // --------------------------------------------------
    // one pixel per clock

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (h_cnt == h_last)
        begin
            h_cnt <= '0;
            if (v_cnt == v_last)
                v_cnt <= '0;
            else
                v_cnt <= v_cnt + 1'b1;
        end
        else
        begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    always_comb
    begin
        sync.hsync      = !(h_cnt >= h_sync_start && h_cnt < h_sync_end);
        sync.vsync      = !(v_cnt >= v_sync_start && v_cnt < v_sync_end);
        sync.display_on = (h_cnt < h_vis) && (v_cnt < v_vis);
        pos.x           = h_cnt;
        pos.y           = v_cnt;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the board_top testbench with Verilator.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module board_top_tb \
    -Mdir "$build_dir" \
    -f board_demo.f
if [ $? -ne 0 ]; then
    echo "run_sim: Verilator build failed"
    exit 1
fi

"./$build_dir/Vboard_top_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "Simulation finished: FAIL" "$log_file"; then
    echo "run_sim: testbench reported failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "run_sim: simulation exited with status $run_status"
    exit 1
fi

echo "run_sim: done"
exit 0

/* tb/board_top_asserts.sv */
`timescale 1ns/1ns

module board_top_asserts
#(
    parameter h_sync  = 96,
              w_digit = 4
)
(
    input logic                 clk,
    input logic                 rst,
    input logic                 hsync,
    input logic [w_digit - 1:0] digit
);

    logic [15:0] hsync_low;     // clocks spent low so far
    logic        out_of_reset;  // digit is zero for one cycle after reset

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            hsync_low    <= '0;
            out_of_reset <= 1'b0;
        end
        else
        begin
            hsync_low    <= hsync ? '0 : hsync_low + 1'b1;
            out_of_reset <= 1'b1;
        end
    end

    // --------------------------------------------------

    hsync_width: assert property (@(posedge clk) disable iff (rst)
        $rose(hsync) |-> hsync_low == 16'(h_sync))
        else $error("hsync was low for %0d clocks instead of %0d", hsync_low, h_sync);

    hsync_not_long: assert property (@(posedge clk) disable iff (rst)
        hsync_low <= 16'(h_sync))
        else $error("hsync low longer than %0d clocks", h_sync);

    digit_one_hot: assert property (@(posedge clk) disable iff (rst)
        out_of_reset |-> $onehot(digit))
        else $error("digit select %b is not one-hot", digit);

endmodule

bind lab_top board_top_asserts #(.h_sync(h_sync), .w_digit(w_digit)) i_board_top_asserts
(
    .clk   ( clk            ),
    .rst   ( rst            ),
    .hsync ( raw_sync.hsync ),
    .digit ( digit          )
);

/* tb/board_top_tb.sv */
`timescale 1ns/1ns

module board_top_tb;

    localparam int clk_mhz = 1, slow_clk_hz = 10000, sck_div = 2;
    localparam int w_key = 4, w_sw = 5, w_led = 6, w_digit = 4;
    localparam int h_visible = 16, h_front = 2, h_sync = 3, h_back = 2;
    localparam int v_visible = 8,  v_front = 2, v_sync = 3, v_back = 2;
    localparam int h_total = h_visible + h_front + h_sync + h_back;
    localparam int v_total = v_visible + v_front + v_sync + v_back;
    localparam int w_mic = board_pkg::w_mic;
    localparam int cycle_limit = 20000;  // tests need about 3500 cycles

    logic clk = 1'b0, rst = 1'b1, mic_sd = 1'b0;
    logic [w_key - 1:0] key = '1;
    logic [w_sw  - 1:0] sw  = '1;
    logic [w_led - 1:0] led;
    logic [7:0] abcdefgh, gpio_2;
    logic [w_digit - 1:0] digit;
    logic [5:0] gpio_3;
    logic mic_sck, mic_ws, mic_lr, prev_sck = 1'b0, prev_ws = 1'b0;
    logic [w_mic - 1:0] sent_word = '0;
    int cycles = 0, scan_cycle = 0, sd_bit = 0;

    board_top #(.clk_mhz(clk_mhz), .slow_clk_hz(slow_clk_hz), .sck_div(sck_div),
        .w_key(w_key), .w_sw(w_sw), .w_led(w_led), .w_digit(w_digit),
        .h_visible(h_visible), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
        .v_visible(v_visible), .v_front(v_front), .v_sync(v_sync), .v_back(v_back))
    i_board_top (.clk(clk), .rst(rst), .key(key), .sw(sw), .led(led), .abcdefgh(abcdefgh),
        .digit(digit), .mic_sck(mic_sck), .mic_ws(mic_ws), .mic_lr(mic_lr), .mic_sd(mic_sd),
        .gpio_2(gpio_2), .gpio_3(gpio_3));

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit)
            stop_with_failure("timeout, the tests did not finish within the cycle limit");
    end

    // --------------------------------------------------
    // INMP441 model drives the MSB one sck after ws falls

    always @(posedge clk)
    begin
        if (rst)
        begin
            mic_sd <= 1'b0;
            sd_bit = 0;
        end
        else if (prev_sck && !mic_sck)  // sck fell on the last edge
        begin
            if (prev_ws && !mic_ws)
            begin
                sent_word = w_mic'($urandom);  // new left slot
                sd_bit    = 0;
            end
            else
                sd_bit = sd_bit + 1;
            mic_sd <= (sd_bit >= 1 && sd_bit <= w_mic) ? sent_word[w_mic - sd_bit] : 1'b0;
        end
        prev_sck = mic_sck;
        prev_ws  = mic_ws;
    end

    // --------------------------------------------------

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, expected);
            stop_with_failure("value mismatch");
        end
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clk);
    endtask

    // {valid, hex} from the gfedcba segment pattern
    function automatic logic [4:0] decode_segments(input logic [6:0] gfedcba);
        case (gfedcba)
            7'h3f: return 5'h10;
            7'h06: return 5'h11;
            7'h5b: return 5'h12;
            7'h4f: return 5'h13;
            7'h66: return 5'h14;
            7'h6d: return 5'h15;
            7'h7d: return 5'h16;
            7'h07: return 5'h17;
            7'h7f: return 5'h18;
            7'h6f: return 5'h19;
            7'h77: return 5'h1a;
            7'h7c: return 5'h1b;
            7'h39: return 5'h1c;
            7'h5e: return 5'h1d;
            7'h79: return 5'h1e;
            7'h71: return 5'h1f;
            default: return 5'h00;
        endcase
    endfunction

    // leds lit from the top bit down as the magnitude reaches them
    function automatic logic [w_led - 1:0] expected_bar(input logic [w_mic - 1:0] sample);
        logic [w_mic - 1:0] mag;
        logic [w_led - 1:0] bar;
        int top;
        mag = sample[w_mic - 1] ? (~sample) + 1'b1 : sample;
        top = -1;
        for (int b = 0; b < w_mic; b++)
            if (mag[b])
                top = b;
        for (int j = 0; j < w_led; j++)
            bar[j] = (top >= w_mic - w_led + j);
        return bar;
    endfunction

    task automatic read_display(output logic [15:0] word);
        logic [4:0] decoded;
        word = '0;
        for (int k = 0; k < w_digit; k++)
        begin
            @(posedge clk);
            while (digit !== (4'(1) << k))
                @(posedge clk);
            if (k == 0)
                scan_cycle = cycles;
            decoded = decode_segments(abcdefgh[6:0]);  // h is bit 7
            check_value("abcdefgh[7]", 32'(abcdefgh[7]), 32'(0));
            check_value("segment pattern known", 32'(decoded[4]), 32'(1));
            word[4 * k +: 4] = decoded[3:0];
        end
    endtask

    task automatic wait_ws_rise;
        @(posedge clk);
        while (mic_ws !== 1'b0)
            @(posedge clk);
        while (mic_ws !== 1'b1)
            @(posedge clk);
    endtask

    // --------------------------------------------------
    // directed tests

    task automatic test_reset;
        @(posedge clk);
        check_value("led", 32'(led), 32'(6'h3f));
        check_value("mic_sck", 32'(mic_sck), 32'(0));
        check_value("mic_ws", 32'(mic_ws), 32'(0));
        check_value("mic_lr", 32'(mic_lr), 32'(0));
        check_value("digit", 32'(digit), 32'(0));
        check_value("gpio_3 sync", 32'(gpio_3[5:4]), 32'(2'b11));
    endtask

    // runs early so the count stays within one hex digit
    task automatic test_count;
        logic [15:0] first, second;
        int first_at, steps, grown, allowed;
        @(posedge clk);
        sw  <= ~w_sw'(board_pkg::mode_count);
        key <= '1;
        wait_clocks(4);
        read_display(first);
        first_at = scan_cycle;
        wait_clocks(600);
        read_display(second);
        steps   = (scan_cycle - first_at + 50) / 100;
        grown   = int'(second) - int'(first);
        allowed = (grown >= steps - 1 && grown <= steps + 1) ? grown : steps;  // within one
        check_value("count growth", 32'(grown), 32'(allowed));
    endtask

    task automatic test_mic;
        logic [w_mic - 1:0] expected;
        logic [w_led - 1:0] led_exp;
        logic [15:0] shown;
        @(posedge clk);
        sw <= ~w_sw'(board_pkg::mode_mic);
        wait_ws_rise();
        for (int i = 0; i < 3; i++)
        begin
            wait_ws_rise();
            expected = sent_word;
            read_display(shown);
            led_exp = ~expected_bar(expected);
            check_value("display in mic mode", 32'(shown), 32'(expected[w_mic - 1 -: 16]));
            check_value("led bar", 32'(led), 32'(led_exp));
        end
    endtask

    task automatic test_keys(input logic [w_key - 1:0] key_true,
                             input logic [w_sw - 1:0] sw_true);
        logic [15:0] shown, disp_exp;
        logic [w_led - 1:0] led_exp;
        @(posedge clk);
        key <= ~key_true;
        sw  <= ~sw_true;
        wait_clocks(4);
        read_display(shown);
        disp_exp = {8'(sw_true), 8'(key_true)};
        led_exp  = ~w_led'(key_true);
        check_value("display in keys mode", 32'(shown), 32'(disp_exp));
        check_value("led", 32'(led), 32'(led_exp));
    endtask

    task automatic check_frame(input logic key_held);
        int h, v, hs_low, vs_low;
        logic vis;
        logic [3:0] blue;
        @(posedge clk);
        key <= key_held ? 4'b1110 : 4'b1111;
        @(posedge clk);
        while (gpio_3[5] !== 1'b1)
            @(posedge clk);
        while (gpio_3[5] !== 1'b0)
            @(posedge clk);
        h = 0;  // vsync falls on the first pixel of a line
        v = v_visible + v_front;
        hs_low = 0;
        vs_low = 0;
        for (int n = 0; n < h_total * v_total; n++)
        begin
            vis  = (h < h_visible) && (v < v_visible);
            blue = (vis && key_held) ? 4'hf : 4'h0;
            check_value("gpio_2", 32'(gpio_2), 32'({blue, vis ? 4'(h) : 4'h0}));
            check_value("gpio_3", 32'(gpio_3),
                32'({!(v >= v_visible + v_front && v < v_visible + v_front + v_sync),
                     !(h >= h_visible + h_front && h < h_visible + h_front + h_sync),
                     vis ? 4'(v) : 4'h0}));
            if (!gpio_3[4])
                hs_low++;
            else if (hs_low != 0)
            begin
                check_value("hsync low width", 32'(hs_low), 32'(h_sync));
                hs_low = 0;
            end
            if (!gpio_3[5])
                vs_low++;
            else if (vs_low != 0)
            begin
                check_value("vsync low width", 32'(vs_low), 32'(v_sync * h_total));
                vs_low = 0;
            end
            @(posedge clk);
            h++;
            if (h == h_total)
            begin
                h = 0;
                v = (v == v_total - 1) ? 0 : v + 1;
            end
        end
    endtask

    initial
    begin
        void'($urandom(32'hda5f_c714));
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_count();
        test_mic();
        test_keys(4'b0101, 5'b00001);
        test_keys(4'b1001, 5'b10101);
        check_frame(1'b0);
        check_frame(1'b1);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
